// ==== icache_pkg.sv ====
// ==========================================================
// Shared geometry, AXI IDs and enums for the instruction cache.
// Modules refer to these by scoped names.
// ==========================================================
package icache_pkg;

    localparam int word_w        = 32;
    localparam int line_words    = 16;
    localparam int word_off_bits = 4;   // log2 of line_words.

    localparam int axi_id_w = 4;

    localparam logic [axi_id_w-1:0] arid_cached   = 4'd3;  // line refill bursts.
    localparam logic [axi_id_w-1:0] arid_uncached = 4'd2;  // single uncached words.

    // refill engine states
    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_fill,
        st_done
    } refill_state_e;

    // cache operations issued by the core
    typedef enum logic [1:0] {
        op_none,
        op_index_inv,
        op_hit_inv
    } cache_op_e;

endpackage

// ==== icache_data_ram.sv ====
// ==========================================================
// Line data storage with one clocked write port and one
// combinational read port, indexed by line and word offset.
// ==========================================================
`timescale 1ns/1ps

module icache_data_ram #(
    parameter int index_bits = 6
) (
    input  logic                                          aclk,
    input  logic                                          wen,
    input  logic [index_bits+icache_pkg::word_off_bits-1:0] waddr,
    input  logic [icache_pkg::word_w-1:0]                   wdata,
    input  logic [index_bits+icache_pkg::word_off_bits-1:0] raddr,
    output logic [icache_pkg::word_w-1:0]                   rdata
);

    localparam int depth = icache_pkg::line_words << index_bits;

    logic [icache_pkg::word_w-1:0] mem [depth];

    always_ff @(posedge aclk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr]; // contents only matter once the line is valid.

endmodule

// ==== icache_tag_store.sv ====
// ==========================================================
// Tag and valid arrays of the direct-mapped cache. Produces the
// hit flag for bus_addr and applies refill and invalidate updates.
// ==========================================================
`timescale 1ns/1ps

module icache_tag_store #(
    parameter int index_bits = 6
) (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic [icache_pkg::word_w-1:0] bus_addr,
    input  logic                          cop_en,
    input  icache_pkg::cache_op_e         cacheop,
    input  logic [icache_pkg::word_w-1:0] cop_addr,
    input  logic                          tag_load,
    input  logic [icache_pkg::word_w-1:0] load_addr,
    input  logic                          load_done,
    output logic                          line_hit
);

    localparam int line_off = icache_pkg::word_off_bits + 2;
    localparam int tag_w    = icache_pkg::word_w - line_off - index_bits;
    localparam int lines    = 1 << index_bits;

    logic [tag_w-1:0]      tag_mem [lines];
    logic [lines-1:0]      valid_q;
    logic                  fill_busy;   // set from tag load until the line is complete.
    logic                  cop_clear;

    logic [index_bits-1:0] bus_idx;
    logic [index_bits-1:0] cop_idx;
    logic [index_bits-1:0] load_idx;
    logic [tag_w-1:0]      bus_tag;
    logic [tag_w-1:0]      cop_tag;
    logic [tag_w-1:0]      load_tag;

    assign bus_idx  = bus_addr[line_off +: index_bits];
    assign cop_idx  = cop_addr[line_off +: index_bits];
    assign load_idx = load_addr[line_off +: index_bits];
    assign bus_tag  = bus_addr[icache_pkg::word_w-1 -: tag_w];
    assign cop_tag  = cop_addr[icache_pkg::word_w-1 -: tag_w];
    assign load_tag = load_addr[icache_pkg::word_w-1 -: tag_w];

    assign line_hit = valid_q[bus_idx] && (tag_mem[bus_idx] == bus_tag);

    // cache operations are ignored while a line fill is in flight.
    always_comb begin
        cop_clear = 1'b0;
        if (cop_en && !fill_busy) begin
            case (cacheop)
                icache_pkg::op_index_inv: cop_clear = 1'b1;
                icache_pkg::op_hit_inv:   cop_clear = (tag_mem[cop_idx] == cop_tag);
                default:                  cop_clear = 1'b0;
            endcase
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid_q   <= '0;
            fill_busy <= 1'b0;
        end else begin
            if (cop_clear) begin
                valid_q[cop_idx] <= 1'b0;
            end
            if (tag_load) begin
                valid_q[load_idx] <= 1'b0; // a refill overrides an op on the same line.
                fill_busy         <= 1'b1;
            end
            if (load_done) begin
                valid_q[load_idx] <= 1'b1;
                fill_busy         <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (tag_load) begin
            tag_mem[load_idx] <= load_tag;
        end
    end

endmodule

// ==== icache_refill.sv ====
// ==========================================================
// Miss handling: refill FSM, AXI read address and data master,
// the one-word uncached buffer and the core-side stall and data.
// ==========================================================
`timescale 1ns/1ps

module icache_refill #(
    parameter int index_bits = 6
) (
    input  logic                                            aclk,
    input  logic                                            aresetn,
    input  logic                                            bus_en,
    input  logic [icache_pkg::word_w-1:0]                   bus_addr,
    input  logic                                            bus_cached,
    input  logic                                            bus_stall,
    input  logic                                            line_hit,
    input  logic [icache_pkg::word_w-1:0]                   ram_rdata,
    input  logic                                            arready,
    input  logic [icache_pkg::word_w-1:0]                   rdata,
    input  logic                                            rlast,
    input  logic                                            rvalid,
    output logic                                            bus_streq,
    output logic [icache_pkg::word_w-1:0]                   bus_rdata,
    output logic                                            tag_load,
    output logic [icache_pkg::word_w-1:0]                   load_addr,
    output logic                                            load_done,
    output logic                                            ram_wen,
    output logic [index_bits+icache_pkg::word_off_bits-1:0] ram_waddr,
    output logic [icache_pkg::word_w-1:0]                   ram_wdata,
    output logic [icache_pkg::axi_id_w-1:0]                 arid,
    output logic [icache_pkg::word_w-1:0]                   araddr,
    output logic [3:0]                                      arlen,
    output logic                                            arvalid,
    output logic                                            rready
);

    localparam int line_off = icache_pkg::word_off_bits + 2;
    localparam logic [3:0] burst_len = 4'(icache_pkg::line_words - 1);

    icache_pkg::refill_state_e state_q;

    logic [icache_pkg::word_w-1:0]        req_addr;
    logic                                 req_cached;
    logic [icache_pkg::word_off_bits-1:0] beat_cnt;
    logic [index_bits-1:0]                req_idx;

    logic [icache_pkg::word_w-1:0] unc_data;
    logic [icache_pkg::word_w-1:0] unc_addr;
    logic                          unc_valid;
    logic                          unc_hit;

    logic path_hit;
    logic miss;
    logic beat;

    assign req_idx  = req_addr[line_off +: index_bits];
    assign unc_hit  = unc_valid && (unc_addr == bus_addr);
    assign path_hit = bus_cached ? line_hit : unc_hit;
    assign miss     = bus_en && !path_hit;
    assign beat     = rvalid && rready;

    assign bus_streq = miss;
    assign bus_rdata = bus_cached ? ram_rdata : unc_data;

    assign rready = (state_q == icache_pkg::st_fill);

    // the tag is written in the miss cycle itself, the valid bit once the line is in.
    assign tag_load  = (state_q == icache_pkg::st_idle) && miss && bus_cached;
    assign load_done = (state_q == icache_pkg::st_done) && req_cached;
    assign load_addr = (state_q == icache_pkg::st_idle) ? bus_addr : req_addr;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q   <= icache_pkg::st_idle;
            arvalid   <= 1'b0;
            arid      <= '0;
            araddr    <= '0;
            arlen     <= '0;
            beat_cnt  <= '0;
            ram_wen   <= 1'b0;
            unc_valid <= 1'b0;
        end else begin
            ram_wen <= 1'b0;
            case (state_q)
                icache_pkg::st_idle: begin
                    if (miss) begin
                        state_q <= icache_pkg::st_request;
                    end
                end
                icache_pkg::st_request: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        state_q <= icache_pkg::st_fill;
                    end else if (!arvalid) begin
                        arvalid  <= 1'b1;  // request fields stay put until accepted.
                        arid     <= req_cached ? icache_pkg::arid_cached
                                               : icache_pkg::arid_uncached;
                        araddr   <= req_addr;
                        arlen    <= req_cached ? burst_len : 4'd0;
                        beat_cnt <= '0;
                    end
                end
                icache_pkg::st_fill: begin
                    if (beat) begin
                        ram_wen  <= req_cached;
                        beat_cnt <= beat_cnt + 1'b1;
                        if (rlast) begin
                            state_q   <= icache_pkg::st_done;
                            unc_valid <= !req_cached;
                        end
                    end
                end
                icache_pkg::st_done: begin
                    // an uncached word is held until the core can take it.
                    if (req_cached || !bus_stall) begin
                        state_q   <= icache_pkg::st_idle;
                        unc_valid <= 1'b0;
                    end
                end
                default: state_q <= icache_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if ((state_q == icache_pkg::st_idle) && miss) begin
            req_cached <= bus_cached;
            req_addr   <= bus_cached ? {bus_addr[icache_pkg::word_w-1:line_off],
                                        {line_off{1'b0}}}
                                     : bus_addr;
        end
        if (beat) begin
            ram_waddr <= {req_idx, beat_cnt};  // bursts always start at word zero.
            ram_wdata <= rdata;
            if (!req_cached) begin
                unc_data <= rdata;
                unc_addr <= req_addr;
            end
        end
    end

endmodule

// ==== icache_top.sv ====
// ==========================================================
// Instruction cache top level with an AXI4 read master. Joins
// the tag store, the line data RAM and the refill engine.
// ==========================================================
`timescale 1ns/1ps

module icache_top #(
    parameter int index_bits = 6
) (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            bus_en,
    input  logic [icache_pkg::word_w-1:0]   bus_addr,
    input  logic                            bus_cached,
    input  logic                            bus_stall,
    output logic [icache_pkg::word_w-1:0]   bus_rdata,
    output logic                            bus_streq,
    input  icache_pkg::cache_op_e           cacheop,
    input  logic                            cop_en,
    input  logic [icache_pkg::word_w-1:0]   cop_addr,
    output logic [icache_pkg::axi_id_w-1:0] arid,
    output logic [icache_pkg::word_w-1:0]   araddr,
    output logic [3:0]                      arlen,
    output logic                            arvalid,
    input  logic                            arready,
    input  logic [icache_pkg::word_w-1:0]   rdata,
    input  logic                            rlast,
    input  logic                            rvalid,
    output logic                            rready
);

    localparam int ram_aw = index_bits + icache_pkg::word_off_bits;

    logic                          line_hit;
    logic                          tag_load;
    logic [icache_pkg::word_w-1:0] load_addr;
    logic                          load_done;
    logic                          ram_wen;
    logic [ram_aw-1:0]             ram_waddr;
    logic [icache_pkg::word_w-1:0] ram_wdata;
    logic [icache_pkg::word_w-1:0] ram_rdata;

    icache_tag_store #(.index_bits(index_bits)) u_tag_store (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .bus_addr  (bus_addr),
        .cop_en    (cop_en),
        .cacheop   (cacheop),
        .cop_addr  (cop_addr),
        .tag_load  (tag_load),
        .load_addr (load_addr),
        .load_done (load_done),
        .line_hit  (line_hit)
    );

    icache_data_ram #(.index_bits(index_bits)) u_data_ram (
        .aclk  (aclk),
        .wen   (ram_wen),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (bus_addr[ram_aw+1:2]),  // line index and word offset of the fetch.
        .rdata (ram_rdata)
    );

    icache_refill #(.index_bits(index_bits)) u_refill (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .bus_en     (bus_en),
        .bus_addr   (bus_addr),
        .bus_cached (bus_cached),
        .bus_stall  (bus_stall),
        .line_hit   (line_hit),
        .ram_rdata  (ram_rdata),
        .arready    (arready),
        .rdata      (rdata),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .bus_streq  (bus_streq),
        .bus_rdata  (bus_rdata),
        .tag_load   (tag_load),
        .load_addr  (load_addr),
        .load_done  (load_done),
        .ram_wen    (ram_wen),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata),
        .arid       (arid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arvalid    (arvalid),
        .rready     (rready)
    );

endmodule

// ==== icache_assertions.sv ====
// ==========================================================
// AXI read channel protocol assertions, bound into the refill
// engine so that they see its ports directly.
// ==========================================================
`timescale 1ns/1ps

module icache_assertions (
    input logic        aclk,
    input logic        aresetn,
    input logic        arvalid,
    input logic        arready,
    input logic [3:0]  arid,
    input logic [31:0] araddr,
    input logic [3:0]  arlen,
    input logic        rready
);

    int violations = 0;

    ar_held: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid) && $stable(arlen))
        else begin
            $error("read address request changed or dropped before arready");
            violations++;
        end

    // data is only accepted once the address phase is over.
    r_after_ar: assert property (@(posedge aclk) disable iff (!aresetn) !(rready && arvalid))
        else begin
            $error("rready and arvalid are high in the same cycle");
            violations++;
        end

    ar_idle_after_reset: assert property (@(posedge aclk) $rose(aresetn) |-> !arvalid)
        else begin
            $error("arvalid is high in the first cycle after reset");
            violations++;
        end

endmodule

bind icache_refill icache_assertions u_assertions (
    .aclk    (aclk),
    .aresetn (aresetn),
    .arvalid (arvalid),
    .arready (arready),
    .arid    (arid),
    .araddr  (araddr),
    .arlen   (arlen),
    .rready  (rready)
);

// ==== icache_checker.sv ====
// ==========================================================
// Watches the core and AXI read ports of the cache, compares
// them with the current case and prints one line per case.
// ==========================================================
`timescale 1ns/1ps

module icache_checker (
    input  logic        aclk,
    input  logic        aresetn,
    input  logic        bus_en,
    input  logic        bus_streq,
    input  logic [31:0] bus_rdata,
    input  logic        arvalid,
    input  logic        arready,
    input  logic [3:0]  arid,
    input  logic [31:0] araddr,
    input  logic [3:0]  arlen,
    input  logic        case_end,
    input  int          case_idx,
    input  logic        exp_fetch,
    input  logic        exp_cached,
    input  logic [31:0] exp_addr,
    input  logic [31:0] exp_word,
    input  logic        exp_ar,
    output int          tests_passed,
    output int          tests_failed
);

    int          errors = 0;
    int          ar_seen = 0;
    int          stall_cycles = 0;
    logic [3:0]  exp_arid;
    logic [3:0]  exp_arlen;
    logic [31:0] exp_araddr;

    // refills use id 3 and 16 beats from the line start, uncached reads id 2 and one beat.
    assign exp_arid   = exp_cached ? 4'd3 : 4'd2;
    assign exp_arlen  = exp_cached ? 4'd15 : 4'd0;
    assign exp_araddr = exp_cached ? {exp_addr[31:6], 6'd0} : exp_addr;

    initial begin
        tests_passed = 0;
        tests_failed = 0;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected, actual);
        $display("Mismatch at %0t ns: %s expected %08h, actual %08h",
                 $time, name, expected, actual);
        errors++;
    endtask

    always @(posedge aclk) begin
        if (aresetn) begin
            if (bus_en && bus_streq) begin
                stall_cycles++;
            end
            if (bus_en && !bus_streq) begin
                if (bus_rdata !== exp_word) report_mismatch("bus_rdata", exp_word, bus_rdata);
            end
            if (arvalid && arready) begin
                ar_seen++;
                if (arid !== exp_arid) report_mismatch("arid", exp_arid, arid);
                if (arlen !== exp_arlen) report_mismatch("arlen", exp_arlen, arlen);
                if (araddr !== exp_araddr) report_mismatch("araddr", exp_araddr, araddr);
            end
            if (case_end) begin
                if (ar_seen != (exp_ar ? 1 : 0)) begin
                    $display("case %0d: expected %0d read requests but saw %0d",
                             case_idx, exp_ar ? 1 : 0, ar_seen);
                    errors++;
                end
                // a hit in a valid line answers in the cycle the address is presented.
                if (exp_fetch && exp_cached && !exp_ar && stall_cycles != 0) begin
                    $display("case %0d: the hit stalled the core for %0d cycles",
                             case_idx, stall_cycles);
                    errors++;
                end
                if (errors == 0) begin
                    tests_passed++;
                    $display("case %0d at %08h: ok", case_idx, exp_addr);
                end else begin
                    tests_failed++;
                    $display("case %0d at %08h: failed with %0d errors",
                             case_idx, exp_addr, errors);
                end
                errors       = 0;
                ar_seen      = 0;
                stall_cycles = 0;
            end
        end
    end

endmodule

// ==== tb_icache.sv ====
// ==========================================================
// Testbench for the instruction cache. Runs the cases from the
// case file against an AXI read memory model.
// ==========================================================
`timescale 1ns/1ps

module tb_icache;

    localparam int index_bits = 6;
    localparam logic [31:0] mem_key = 32'hA5A50000;  // memory word at A is A xor this key.

    logic                  aclk = 1'b0;
    logic                  aresetn;
    logic                  bus_en, bus_cached, bus_stall, bus_streq, cop_en;
    logic [31:0]           bus_addr, bus_rdata, cop_addr;
    icache_pkg::cache_op_e cacheop;
    logic [3:0]            arid, arlen;
    logic [31:0]           araddr, rdata;
    logic                  arvalid, arready, rvalid, rlast, rready;

    logic [31:0] case_op[$], case_addr[$], case_word[$], case_ar[$];
    logic        case_end, exp_fetch, exp_cached, exp_ar;
    logic [31:0] exp_addr, exp_word;
    int          case_idx, n_cases, tests_passed, tests_failed;
    int          cycles = 0;
    int          cycle_limit = 1000;

    logic [31:0] lcg_state = 32'd28388;
    logic        ar_taken = 1'b0;
    logic        r_taken = 1'b0;
    logic [31:0] ar_addr_q, beat_addr;
    logic [3:0]  ar_len_q;
    int          ar_wait = -1;
    int          beats_left = 0;

    always #4 aclk = ~aclk;

    icache_top #(.index_bits(index_bits)) u_icache_top (.*);

    icache_checker u_checker (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        string       text;
        logic [31:0] f_op, f_addr, f_word, f_ar;
        fd = $fopen("icache_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open icache_cases.txt, no cases were run");
        end else begin
            while ($fgets(text, fd) != 0) begin
                n = $sscanf(text, "%h %h %h %h", f_op, f_addr, f_word, f_ar);
                if (text[0] != "#" && n == 4) begin
                    case_op.push_back(f_op);
                    case_addr.push_back(f_addr);
                    case_word.push_back(f_word);
                    case_ar.push_back(f_ar);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_fetch(input logic [31:0] op);
        int   held;
        logic done;
        held       = 0;
        done       = 1'b0;
        bus_en     = 1'b1;
        bus_addr   = exp_addr;
        bus_cached = (op == 0);
        bus_stall  = (op == 4);
        while (!done) begin
            @(posedge aclk);
            if (!bus_streq && !bus_stall) begin
                done = 1'b1;
            end else if (!bus_streq) begin
                held = held + 1;
                if (held == 3) begin
                    @(negedge aclk);
                    bus_stall = 1'b0;  // the core takes the word after three held cycles.
                end
            end
        end
    endtask

    // handshakes are seen on the rising edge and answered on the falling edge.
    always @(posedge aclk) begin
        ar_taken  <= arvalid && arready;
        r_taken   <= rvalid && rready;
        ar_addr_q <= araddr;
        ar_len_q  <= arlen;
    end

    always @(negedge aclk) begin
        if (!aresetn) begin
            arready    = 1'b0;
            rvalid     = 1'b0;
            rlast      = 1'b0;
            beats_left = 0;
            ar_wait    = -1;
        end else begin
            if (r_taken) begin
                rvalid     = 1'b0;
                rlast      = 1'b0;
                beats_left = beats_left - 1;
                beat_addr  = beat_addr + 32'd4;
            end
            if (ar_taken) begin
                arready    = 1'b0;
                beat_addr  = ar_addr_q;
                beats_left = int'(ar_len_q) + 1;
            end else if (arvalid && !arready && beats_left == 0) begin
                if (ar_wait < 0) ar_wait = int'(lcg_next() % 4);
                if (ar_wait == 0) arready = 1'b1;
                ar_wait = ar_wait - 1;
            end
            if (beats_left > 0 && !rvalid && (lcg_next() % 3) != 0) begin
                rvalid = 1'b1;
                rlast  = (beats_left == 1);
                rdata  = beat_addr ^ mem_key;
            end
        end
    end

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the cache stopped responding", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        aresetn    = 1'b0;
        bus_en     = 1'b0;
        bus_addr   = '0;
        bus_cached = 1'b0;
        bus_stall  = 1'b0;
        cacheop    = icache_pkg::op_none;
        cop_en     = 1'b0;
        cop_addr   = '0;
        arready    = 1'b0;
        rdata      = '0;
        rlast      = 1'b0;
        rvalid     = 1'b0;
        case_end   = 1'b0;
        case_idx   = 0;
        exp_fetch  = 1'b0;
        exp_cached = 1'b0;
        exp_ar     = 1'b0;
        exp_addr   = '0;
        exp_word   = '0;
        load_cases();
        n_cases     = case_op.size();
        cycle_limit = n_cases * 200 + 20;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        for (int i = 0; i < n_cases; i++) begin
            @(negedge aclk);
            case_end   = 1'b0;
            case_idx   = i;
            exp_addr   = case_addr[i];
            exp_word   = case_word[i];
            exp_ar     = case_ar[i][0];
            exp_fetch  = (case_op[i] < 2) || (case_op[i] == 4);
            exp_cached = (case_op[i] == 0);
            if (exp_fetch) begin
                run_fetch(case_op[i]);
            end else begin
                cop_en   = 1'b1;
                cop_addr = case_addr[i];
                if (case_op[i] == 2) cacheop = icache_pkg::op_index_inv;
                else cacheop = icache_pkg::op_hit_inv;
            end
            @(negedge aclk);
            bus_en    = 1'b0;
            bus_stall = 1'b0;
            cop_en    = 1'b0;
            case_end  = 1'b1;
        end
        @(negedge aclk);
        case_end = 1'b0;
        repeat (2) @(posedge aclk);
        $display("%0d cases: %0d passed, %0d failed, %0d assertion failures", n_cases,
                 tests_passed, tests_failed, u_icache_top.u_refill.u_assertions.violations);
        if (n_cases > 0 && tests_failed == 0 && tests_passed == n_cases &&
            u_icache_top.u_refill.u_assertions.violations == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
icache_pkg.sv
icache_data_ram.sv
icache_tag_store.sv
icache_refill.sv
icache_top.sv
icache_assertions.sv
icache_checker.sv
tb_icache.sv

// ==== icache_cases.txt ====
# op (0 cached, 1 uncached, 2 index-inv, 3 hit-inv, 4 uncached with stall), address,
# expected word (address xor a5a50000, zero for cache ops), 1 if a read request is expected
0 00001048 a5a51048 1
0 00001040 a5a51040 0
0 0000107c a5a5107c 0
0 00001060 a5a51060 0
0 00003044 a5a53044 1
0 0000104c a5a5104c 1
1 00002000 a5a52000 1
1 00002000 a5a52000 1
4 00002004 a5a52004 1
1 00001044 a5a51044 1
2 00005040 00000000 0
0 00001050 a5a51050 1
3 00007040 00000000 0
0 00001054 a5a51054 0
3 00001070 00000000 0
0 00001058 a5a51058 1
0 0000105c a5a5105c 0
